// File: hw/rename_pkg.sv
// Shared definitions for the integer rename stage
// Register counts, index types and the rename outcome

package rename_pkg;

  ////////////////////////////////////////////////////////////
  // Register file sizes

  // Architectural integer registers
  localparam int ARCH_REG_COUNT = 32;

  // Physical integer registers
  localparam int PHYS_REG_COUNT = 64;

  localparam int ARCH_IDX_W = $clog2(ARCH_REG_COUNT);
  localparam int PHYS_IDX_W = $clog2(PHYS_REG_COUNT);

  ////////////////////////////////////////////////////////////
  // Index types

  typedef logic [ARCH_IDX_W-1:0] arch_idx_t;
  typedef logic [PHYS_IDX_W-1:0] phys_idx_t;

  ////////////////////////////////////////////////////////////
  // Outcome of one rename cycle

  // NONE when no group was taken or a recover dropped it
  typedef enum logic [1:0] {
    RESULT_NONE     = 2'd0,
    RESULT_RENAMED  = 2'd1,
    RESULT_REJECTED = 2'd2
  } rename_result_e;

endpackage

// File: hw/free_list.sv
`timescale 1ns/1ns
// Free physical register list with lowest-first allocation
// Grant decision against the free count, plus checkpoint snapshots

module free_list #(
  parameter int WAYS = 2,
  parameter int CHECKPOINTS = 4,
  localparam int CP_W = (CHECKPOINTS > 1) ? $clog2(CHECKPOINTS) : 1
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             rename_valid,
  input  logic                             recover,
  input  logic                             check,
  input  logic [WAYS-1:0]                  dst_valid,
  input  logic [CP_W-1:0]                  check_idx,
  input  logic [CP_W-1:0]                  recover_idx,
  input  logic [WAYS-1:0]                  retire_valid,
  input  rename_pkg::phys_idx_t [WAYS-1:0] retire_pdst,
  output logic                             grant,
  output rename_pkg::phys_idx_t [WAYS-1:0] new_pdst
);

  localparam int PHYS = rename_pkg::PHYS_REG_COUNT;
  localparam int ARCH = rename_pkg::ARCH_REG_COUNT;
  localparam int COUNT_W = $clog2(PHYS + 1);
  localparam int REQ_W = $clog2(WAYS + 1);

  // Registers below ARCH hold the initial identity mapping
  localparam logic [PHYS-1:0] RESET_BUSY = {{(PHYS - ARCH){1'b0}}, {ARCH{1'b1}}};
  localparam logic [COUNT_W-1:0] RESET_COUNT = COUNT_W'(PHYS - ARCH);

  // One bit per physical register, set when busy
  logic [PHYS-1:0]    busy;
  logic [COUNT_W-1:0] free_count;
  logic [PHYS-1:0]    busy_snap [CHECKPOINTS];
  logic [COUNT_W-1:0] count_snap [CHECKPOINTS];

  logic [PHYS-1:0]    retire_mask;
  logic [PHYS-1:0]    busy_ret;
  logic [COUNT_W-1:0] count_ret;
  logic [PHYS-1:0]    snap_busy_ret [CHECKPOINTS];
  logic [COUNT_W-1:0] snap_count_ret [CHECKPOINTS];
  logic [PHYS-1:0]    busy_alloc;
  logic [REQ_W-1:0]   req_count;

  function automatic logic [COUNT_W-1:0] count_ones(input logic [PHYS-1:0] bits);
    logic [COUNT_W-1:0] n;
    n = '0;
    for (int p = 0; p < PHYS; p++) begin
      n = n + COUNT_W'(bits[p]);
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // Retire

  always_comb begin
    retire_mask = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (retire_valid[w]) begin
        retire_mask[retire_pdst[w]] = 1'b1;
      end
    end
  end

  // Only registers that were busy add to the free count
  assign busy_ret  = busy & ~retire_mask;
  assign count_ret = free_count + count_ones(busy & retire_mask);

  // Snapshots see the same retires as the live list
  always_comb begin
    for (int k = 0; k < CHECKPOINTS; k++) begin
      snap_busy_ret[k]  = busy_snap[k] & ~retire_mask;
      snap_count_ret[k] = count_snap[k] + count_ones(busy_snap[k] & retire_mask);
    end
  end

  ////////////////////////////////////////////////////////////
  // Grant and allocation

  always_comb begin
    req_count = '0;
    for (int w = 0; w < WAYS; w++) begin
      req_count = req_count + REQ_W'(dst_valid[w]);
    end
  end

  assign grant = rename_valid && !recover && (COUNT_W'(req_count) <= count_ret);

  // Lowest free register goes to the earliest requesting way
  always_comb begin
    logic found;
    busy_alloc = busy_ret;
    for (int w = 0; w < WAYS; w++) begin
      new_pdst[w] = '0;
      found = 1'b0;
      if (dst_valid[w]) begin
        for (int p = 0; p < PHYS; p++) begin
          if (!found && !busy_alloc[p]) begin
            new_pdst[w]   = rename_pkg::phys_idx_t'(p);
            busy_alloc[p] = 1'b1;
            found         = 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // State update

  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= RESET_BUSY;
      free_count <= RESET_COUNT;
    end else if (recover) begin
      busy       <= snap_busy_ret[recover_idx];
      free_count <= snap_count_ret[recover_idx];
    end else if (grant) begin
      busy       <= busy_alloc;
      free_count <= count_ret - COUNT_W'(req_count);
    end else begin
      busy       <= busy_ret;
      free_count <= count_ret;
    end
  end

  // Check saves the list as it stood at the start of the cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int k = 0; k < CHECKPOINTS; k++) begin
        busy_snap[k]  <= RESET_BUSY;
        count_snap[k] <= RESET_COUNT;
      end
    end else begin
      for (int k = 0; k < CHECKPOINTS; k++) begin
        if (check && check_idx == CP_W'(k)) begin
          busy_snap[k]  <= busy;
          count_snap[k] <= free_count;
        end else begin
          busy_snap[k]  <= snap_busy_ret[k];
          count_snap[k] <= snap_count_ret[k];
        end
      end
    end
  end

endmodule

// File: hw/map_table.sv
`timescale 1ns/1ns
// Architectural to physical register map
// Combinational read ports, in-order update and map snapshots

module map_table #(
  parameter int WAYS = 2,
  parameter int CHECKPOINTS = 4,
  localparam int CP_W = (CHECKPOINTS > 1) ? $clog2(CHECKPOINTS) : 1
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             check,
  input  logic                             recover,
  input  logic [CP_W-1:0]                  check_idx,
  input  logic [CP_W-1:0]                  recover_idx,
  input  logic                             grant,
  input  logic [WAYS-1:0]                  dst_valid,
  input  rename_pkg::arch_idx_t [WAYS-1:0] src_a,
  input  rename_pkg::arch_idx_t [WAYS-1:0] src_b,
  input  rename_pkg::arch_idx_t [WAYS-1:0] dst,
  input  rename_pkg::phys_idx_t [WAYS-1:0] new_pdst,
  output rename_pkg::phys_idx_t [WAYS-1:0] map_src_a,
  output rename_pkg::phys_idx_t [WAYS-1:0] map_src_b,
  output rename_pkg::phys_idx_t [WAYS-1:0] map_dst
);

  localparam int ARCH = rename_pkg::ARCH_REG_COUNT;

  // Live map, one physical index per architectural register
  rename_pkg::phys_idx_t [ARCH-1:0] map_q;
  rename_pkg::phys_idx_t [ARCH-1:0] map_next;

  // Saved copies of the whole map
  rename_pkg::phys_idx_t [ARCH-1:0] map_snap [CHECKPOINTS];

  // Reset value, register i maps to physical i
  rename_pkg::phys_idx_t [ARCH-1:0] identity_map;

  always_comb begin
    for (int i = 0; i < ARCH; i++) begin
      identity_map[i] = rename_pkg::phys_idx_t'(i);
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports

  // Values before this cycle's writes
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      map_src_a[w] = map_q[src_a[w]];
      map_src_b[w] = map_q[src_b[w]];
      map_dst[w]   = map_q[dst[w]];
    end
  end

  ////////////////////////////////////////////////////////////
  // Write ports

  // Ways are applied in order so a later way overrides an earlier one
  always_comb begin
    map_next = map_q;
    if (grant) begin
      for (int w = 0; w < WAYS; w++) begin
        if (dst_valid[w]) begin
          map_next[dst[w]] = new_pdst[w];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      map_q <= identity_map;
    end else if (recover) begin
      map_q <= map_snap[recover_idx];
    end else begin
      map_q <= map_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // Snapshots

  // Check captures the map as it was at the start of the cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int k = 0; k < CHECKPOINTS; k++) begin
        map_snap[k] <= identity_map;
      end
    end else if (check) begin
      map_snap[check_idx] <= map_q;
    end
  end

endmodule

// File: hw/rename_group.sv
`timescale 1ns/1ns
// Intra-group dependence resolution
// Forwards earlier ways' new registers to later sources and old mappings

module rename_group #(
  parameter int WAYS = 2
) (
  input  logic                             grant,
  input  logic [WAYS-1:0]                  dst_valid,
  input  rename_pkg::arch_idx_t [WAYS-1:0] src_a,
  input  rename_pkg::arch_idx_t [WAYS-1:0] src_b,
  input  rename_pkg::arch_idx_t [WAYS-1:0] dst,
  input  rename_pkg::phys_idx_t [WAYS-1:0] map_src_a,
  input  rename_pkg::phys_idx_t [WAYS-1:0] map_src_b,
  input  rename_pkg::phys_idx_t [WAYS-1:0] map_dst,
  input  rename_pkg::phys_idx_t [WAYS-1:0] new_pdst,
  output rename_pkg::phys_idx_t [WAYS-1:0] psrc_a,
  output rename_pkg::phys_idx_t [WAYS-1:0] psrc_b,
  output rename_pkg::phys_idx_t [WAYS-1:0] pdst,
  output rename_pkg::phys_idx_t [WAYS-1:0] prev_pdst
);

  ////////////////////////////////////////////////////////////
  // Forwarding from earlier ways

  // Scanning upwards leaves the nearest earlier writer in place
  function automatic rename_pkg::phys_idx_t forward(
    input rename_pkg::arch_idx_t areg,
    input rename_pkg::phys_idx_t table_val,
    input int                    way
  );
    rename_pkg::phys_idx_t value;
    value = table_val;
    for (int j = 0; j < way; j++) begin
      if (grant && dst_valid[j] && dst[j] == areg) begin
        value = new_pdst[j];
      end
    end
    return value;
  endfunction

  ////////////////////////////////////////////////////////////
  // Per-way results

  always_comb begin
    for (int i = 0; i < WAYS; i++) begin
      // Read after write inside the group
      psrc_a[i] = forward(src_a[i], map_src_a[i], i);
      psrc_b[i] = forward(src_b[i], map_src_b[i], i);

      // Write after write gives the earlier way's register as the old one
      if (dst_valid[i]) begin
        pdst[i]      = new_pdst[i];
        prev_pdst[i] = forward(dst[i], map_dst[i], i);
      end else begin
        pdst[i]      = '0;
        prev_pdst[i] = '0;
      end
    end
  end

endmodule

// File: hw/rename_unit.sv
`timescale 1ns/1ns
// Top of the integer rename stage
// Free list, map table and group resolution with a registered result

module rename_unit #(
  parameter int WAYS = 2,
  parameter int CHECKPOINTS = 4,
  localparam int CP_W = (CHECKPOINTS > 1) ? $clog2(CHECKPOINTS) : 1
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             rename_valid,
  input  logic [WAYS-1:0]                  dst_valid,
  input  rename_pkg::arch_idx_t [WAYS-1:0] src_a,
  input  rename_pkg::arch_idx_t [WAYS-1:0] src_b,
  input  rename_pkg::arch_idx_t [WAYS-1:0] dst,
  input  logic                             check,
  input  logic                             recover,
  input  logic [CP_W-1:0]                  check_idx,
  input  logic [CP_W-1:0]                  recover_idx,
  input  logic [WAYS-1:0]                  retire_valid,
  input  rename_pkg::phys_idx_t [WAYS-1:0] retire_pdst,
  output rename_pkg::rename_result_e       result,
  output rename_pkg::phys_idx_t [WAYS-1:0] psrc_a,
  output rename_pkg::phys_idx_t [WAYS-1:0] psrc_b,
  output rename_pkg::phys_idx_t [WAYS-1:0] pdst,
  output rename_pkg::phys_idx_t [WAYS-1:0] prev_pdst
);

  logic                             grant;
  rename_pkg::phys_idx_t [WAYS-1:0] new_pdst;
  rename_pkg::phys_idx_t [WAYS-1:0] map_src_a;
  rename_pkg::phys_idx_t [WAYS-1:0] map_src_b;
  rename_pkg::phys_idx_t [WAYS-1:0] map_dst;
  rename_pkg::phys_idx_t [WAYS-1:0] grp_psrc_a;
  rename_pkg::phys_idx_t [WAYS-1:0] grp_psrc_b;
  rename_pkg::phys_idx_t [WAYS-1:0] grp_pdst;
  rename_pkg::phys_idx_t [WAYS-1:0] grp_prev_pdst;
  rename_pkg::rename_result_e       result_next;

  ////////////////////////////////////////////////////////////
  // Blocks

  free_list #(
    .WAYS        (WAYS),
    .CHECKPOINTS (CHECKPOINTS)
  ) u_free_list (
    .clock        (clock),
    .reset        (reset),
    .rename_valid (rename_valid),
    .recover      (recover),
    .check        (check),
    .dst_valid    (dst_valid),
    .check_idx    (check_idx),
    .recover_idx  (recover_idx),
    .retire_valid (retire_valid),
    .retire_pdst  (retire_pdst),
    .grant        (grant),
    .new_pdst     (new_pdst)
  );

  map_table #(
    .WAYS        (WAYS),
    .CHECKPOINTS (CHECKPOINTS)
  ) u_map_table (
    .clock       (clock),
    .reset       (reset),
    .check       (check),
    .recover     (recover),
    .check_idx   (check_idx),
    .recover_idx (recover_idx),
    .grant       (grant),
    .dst_valid   (dst_valid),
    .src_a       (src_a),
    .src_b       (src_b),
    .dst         (dst),
    .new_pdst    (new_pdst),
    .map_src_a   (map_src_a),
    .map_src_b   (map_src_b),
    .map_dst     (map_dst)
  );

  rename_group #(
    .WAYS (WAYS)
  ) u_rename_group (
    .grant     (grant),
    .dst_valid (dst_valid),
    .src_a     (src_a),
    .src_b     (src_b),
    .dst       (dst),
    .map_src_a (map_src_a),
    .map_src_b (map_src_b),
    .map_dst   (map_dst),
    .new_pdst  (new_pdst),
    .psrc_a    (grp_psrc_a),
    .psrc_b    (grp_psrc_b),
    .pdst      (grp_pdst),
    .prev_pdst (grp_prev_pdst)
  );

  ////////////////////////////////////////////////////////////
  // Output stage

  // A recover drops any group strobed in the same cycle
  always_comb begin
    if (rename_valid && !recover) begin
      result_next = grant ? rename_pkg::RESULT_RENAMED : rename_pkg::RESULT_REJECTED;
    end else begin
      result_next = rename_pkg::RESULT_NONE;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= rename_pkg::RESULT_NONE;
    end else begin
      result <= result_next;
    end
  end

  // Group values, meaningful only alongside RESULT_RENAMED
  always_ff @(posedge clock) begin
    psrc_a    <= grp_psrc_a;
    psrc_b    <= grp_psrc_b;
    pdst      <= grp_pdst;
    prev_pdst <= grp_prev_pdst;
  end

endmodule

// File: testbench/tb_rename_model.svh
// Reference model of the rename stage
// Map, busy vector, snapshots and the per-cycle prediction function
`ifndef TB_RENAME_MODEL_SVH
`define TB_RENAME_MODEL_SVH

// Model state, owned by the checker process
rename_pkg::phys_idx_t model_map [ARCH];
logic [PHYS-1:0]       model_busy;
rename_pkg::phys_idx_t model_map_snap [CHECKPOINTS][ARCH];
logic [PHYS-1:0]       model_busy_snap [CHECKPOINTS];

function automatic void model_reset();
  for (int a = 0; a < ARCH; a++) begin
    model_map[a] = rename_pkg::phys_idx_t'(a);
  end
  for (int p = 0; p < PHYS; p++) begin
    model_busy[p] = (p < ARCH);
  end
  for (int k = 0; k < CHECKPOINTS; k++) begin
    model_map_snap[k]  = model_map;
    model_busy_snap[k] = model_busy;
  end
endfunction

// One cycle: retire, grant, allocate in way order, recover, check
function automatic void model_cycle(
  input  logic                       rv,
  input  logic [WAYS-1:0]            dv,
  input  arch_vec_t                  sa,
  input  arch_vec_t                  sb,
  input  arch_vec_t                  d,
  input  logic                       chk,
  input  logic [CP_W-1:0]            cidx,
  input  logic                       rec,
  input  logic [CP_W-1:0]            ridx,
  input  logic [WAYS-1:0]            retv,
  input  phys_vec_t                  retp,
  output rename_pkg::rename_result_e res,
  output phys_vec_t                  exp_psrc_a,
  output phys_vec_t                  exp_psrc_b,
  output phys_vec_t                  exp_pdst,
  output phys_vec_t                  exp_prev
);
  rename_pkg::phys_idx_t old_map [ARCH];
  rename_pkg::phys_idx_t work_map [ARCH];
  logic [PHYS-1:0]       old_busy;
  logic [PHYS-1:0]       work_busy;
  int                    free_regs;
  int                    needed;
  logic                  granted;
  logic                  found;
  old_map  = model_map;
  work_map = model_map;
  old_busy = model_busy;

  // Retires free the register everywhere, snapshots included
  for (int w = 0; w < WAYS; w++) begin
    if (retv[w]) begin
      model_busy[retp[w]] = 1'b0;
      for (int k = 0; k < CHECKPOINTS; k++) begin
        model_busy_snap[k][retp[w]] = 1'b0;
      end
    end
  end

  free_regs = 0;
  needed    = 0;
  for (int p = 0; p < PHYS; p++) begin
    if (!model_busy[p]) free_regs++;
  end
  for (int w = 0; w < WAYS; w++) begin
    if (dv[w]) needed++;
  end
  granted   = rv && !rec && (needed <= free_regs);
  work_busy = model_busy;

  // Walking the ways in order gives RAW and WAW forwarding for free
  for (int i = 0; i < WAYS; i++) begin
    exp_psrc_a[i] = work_map[sa[i]];
    exp_psrc_b[i] = work_map[sb[i]];
    exp_pdst[i]   = '0;
    exp_prev[i]   = '0;
    if (dv[i]) begin
      exp_prev[i] = work_map[d[i]];
    end
    if (granted && dv[i]) begin
      found = 1'b0;
      for (int p = 0; p < PHYS; p++) begin
        if (!found && !work_busy[p]) begin
          found        = 1'b1;
          work_busy[p] = 1'b1;
          exp_pdst[i]  = rename_pkg::phys_idx_t'(p);
        end
      end
      work_map[d[i]] = exp_pdst[i];
    end
  end

  if (rv && !rec) begin
    res = granted ? rename_pkg::RESULT_RENAMED : rename_pkg::RESULT_REJECTED;
  end else begin
    res = rename_pkg::RESULT_NONE;
  end

  // Recover reads the snapshot before this cycle's check overwrites it
  if (rec) begin
    model_map  = model_map_snap[ridx];
    model_busy = model_busy_snap[ridx];
  end else begin
    model_map  = work_map;
    model_busy = work_busy;
  end
  if (chk) begin
    model_map_snap[cidx]  = old_map;
    model_busy_snap[cidx] = old_busy;
  end
endfunction

`endif

// File: testbench/tb_rename.sv
`timescale 1ns/1ns
// Testbench for the integer rename stage
// Directed and random groups, model-based checker, compare tasks

module tb_rename;

  localparam int WAYS = 2;
  localparam int CHECKPOINTS = 4;
  localparam int CP_W = (CHECKPOINTS > 1) ? $clog2(CHECKPOINTS) : 1;
  localparam int ARCH = rename_pkg::ARCH_REG_COUNT;
  localparam int PHYS = rename_pkg::PHYS_REG_COUNT;

  typedef rename_pkg::arch_idx_t [WAYS-1:0] arch_vec_t;
  typedef rename_pkg::phys_idx_t [WAYS-1:0] phys_vec_t;

  logic                       clock = 1'b0;
  logic                       reset;
  logic                       rename_valid;
  logic [WAYS-1:0]            dst_valid;
  arch_vec_t                  src_a;
  arch_vec_t                  src_b;
  arch_vec_t                  dst;
  logic                       check;
  logic                       recover;
  logic [CP_W-1:0]            check_idx;
  logic [CP_W-1:0]            recover_idx;
  logic [WAYS-1:0]            retire_valid;
  phys_vec_t                  retire_pdst;
  rename_pkg::rename_result_e result;
  phys_vec_t                  psrc_a;
  phys_vec_t                  psrc_b;
  phys_vec_t                  pdst;
  phys_vec_t                  prev_pdst;

  // Prediction for the group sampled at the coming edge
  logic                       pred_valid = 1'b0;
  logic [WAYS-1:0]            pred_dv;
  rename_pkg::rename_result_e pred_result;
  phys_vec_t                  pred_psrc_a;
  phys_vec_t                  pred_psrc_b;
  phys_vec_t                  pred_pdst;
  phys_vec_t                  pred_prev;
  rename_pkg::phys_idx_t      retire_pool [$];
  logic                       rejected_seen = 1'b0;

  `include "tb_rename_model.svh"

  always #4 clock = ~clock;

  rename_unit #(
    .WAYS        (WAYS),
    .CHECKPOINTS (CHECKPOINTS)
  ) uut (
    .clock (clock), .reset (reset), .rename_valid (rename_valid),
    .dst_valid (dst_valid), .src_a (src_a), .src_b (src_b), .dst (dst),
    .check (check), .recover (recover), .check_idx (check_idx),
    .recover_idx (recover_idx), .retire_valid (retire_valid),
    .retire_pdst (retire_pdst), .result (result), .psrc_a (psrc_a),
    .psrc_b (psrc_b), .pdst (pdst), .prev_pdst (prev_pdst)
  );

  ////////////////////////////////////////////////////////////
  // Failure handling and compare tasks

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare_result(input string name, input rename_pkg::rename_result_e expected,
                                input rename_pkg::rename_result_e actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %s got %s", $time, name, expected.name(),
               actual.name());
      abort_run();
    end
  endtask

  task automatic compare_phys(input string name, input phys_vec_t expected,
                              input phys_vec_t actual);
    for (int w = 0; w < WAYS; w++) begin
      if (actual[w] !== expected[w]) begin
        $display("ERROR at %0t ns: %s[%0d] expected %0d got %0d", $time, name, w,
                 expected[w], actual[w]);
        abort_run();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checker on the falling edge where everything is stable

  always @(negedge clock) begin
    if (reset) begin
      model_reset();
      pred_valid = 1'b0;
    end else begin
      if (pred_valid) begin
        compare_result("result", pred_result, result);
        if (pred_result == rename_pkg::RESULT_RENAMED) begin
          compare_phys("psrc_a", pred_psrc_a, psrc_a);
          compare_phys("psrc_b", pred_psrc_b, psrc_b);
          compare_phys("pdst", pred_pdst, pdst);
          compare_phys("prev_pdst", pred_prev, prev_pdst);
          // Old mappings become candidates for later retires
          for (int w = 0; w < WAYS; w++) begin
            if (pred_dv[w]) retire_pool.push_back(pred_prev[w]);
          end
        end
        if (pred_result == rename_pkg::RESULT_REJECTED) rejected_seen = 1'b1;
      end
      pred_dv = dst_valid;
      model_cycle(rename_valid, dst_valid, src_a, src_b, dst, check, check_idx, recover,
                  recover_idx, retire_valid, retire_pdst, pred_result, pred_psrc_a,
                  pred_psrc_b, pred_pdst, pred_prev);
      pred_valid = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus

  // Retire requests are served from the pool of returned old mappings
  task automatic drive_cycle(input logic rv, input logic [WAYS-1:0] dv, input arch_vec_t sa,
                             input arch_vec_t sb, input arch_vec_t d, input logic chk,
                             input logic rec, input logic [CP_W-1:0] idx,
                             input logic [WAYS-1:0] retv);
    phys_vec_t       rp;
    logic [WAYS-1:0] rbits;
    @(posedge clock);
    rp    = '0;
    rbits = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (retv[w] && retire_pool.size() > 0) begin
        rbits[w] = 1'b1;
        rp[w]    = retire_pool.pop_front();
      end
    end
    rename_valid <= rv;
    dst_valid    <= dv;
    src_a        <= sa;
    src_b        <= sb;
    dst          <= d;
    check        <= chk;
    check_idx    <= idx;
    recover      <= rec;
    recover_idx  <= idx;
    retire_valid <= rbits;
    retire_pdst  <= rp;
  endtask

  task automatic idle_cycles(input int n);
    for (int c = 0; c < n; c++) begin
      drive_cycle(1'b0, '0, '0, '0, '0, 1'b0, 1'b0, '0, '0);
    end
  endtask

  task automatic wait_reset_release();
    for (int c = 0; c < 10 && reset; c++) begin
      @(posedge clock);
    end
    if (reset) begin
      $display("Reset was never released");
      abort_run();
    end
  endtask

  initial begin
    int unsigned     seed_value;
    logic            rv;
    logic            chk;
    logic            rec;
    int unsigned     sel;
    seed_value = $urandom(32'hde20_9af9);
    reset <= 1'b1;
    rename_valid <= 1'b0;
    dst_valid <= '0;
    src_a <= '0;
    src_b <= '0;
    dst <= '0;
    check <= 1'b0;
    recover <= 1'b0;
    check_idx <= '0;
    recover_idx <= '0;
    retire_valid <= '0;
    retire_pdst <= '0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    wait_reset_release();

    // Identity map, then RAW and WAW inside one group
    drive_cycle(1'b1, 2'b11, {5'd4, 5'd1}, {5'd5, 5'd2}, {5'd6, 5'd3}, 1'b0, 1'b0, '0, '0);
    drive_cycle(1'b1, 2'b11, {5'd9, 5'd7}, {5'd9, 5'd8}, {5'd9, 5'd9}, 1'b0, 1'b0, '0, '0);
    drive_cycle(1'b1, 2'b00, {5'd6, 5'd9}, {5'd3, 5'd9}, {5'd0, 5'd0}, 1'b0, 1'b0, '0, '0);
    idle_cycles(1);

    // Exhaust the free list, then retire and rename again
    for (int c = 0; c < 40 && !rejected_seen; c++) begin
      drive_cycle(1'b1, 2'b11, {5'd12, 5'd10}, {5'd13, 5'd11}, {5'd11, 5'd10}, 1'b0, 1'b0,
                  '0, '0);
    end
    if (!rejected_seen) begin
      $display("The free list never ran out of registers");
      abort_run();
    end
    drive_cycle(1'b0, '0, '0, '0, '0, 1'b0, 1'b0, '0, 2'b11);
    drive_cycle(1'b1, 2'b11, {5'd12, 5'd10}, {5'd13, 5'd11}, {5'd11, 5'd10}, 1'b0, 1'b0,
                '0, '0);

    // Check, rename, retire in between, recover
    for (int c = 0; c < 4; c++) begin
      drive_cycle(1'b0, '0, '0, '0, '0, 1'b0, 1'b0, '0, 2'b11);
    end
    drive_cycle(1'b0, '0, '0, '0, '0, 1'b1, 1'b0, 2'd1, '0);
    drive_cycle(1'b1, 2'b11, {5'd1, 5'd2}, {5'd3, 5'd4}, {5'd2, 5'd1}, 1'b0, 1'b0, '0, '0);
    drive_cycle(1'b1, 2'b01, {5'd1, 5'd2}, {5'd3, 5'd1}, {5'd0, 5'd3}, 1'b0, 1'b0, '0, 2'b11);
    drive_cycle(1'b0, '0, '0, '0, '0, 1'b0, 1'b1, 2'd1, '0);
    drive_cycle(1'b1, 2'b11, {5'd3, 5'd1}, {5'd2, 5'd2}, {5'd5, 5'd4}, 1'b0, 1'b0, '0, '0);

    // Random mix of groups, retires, checks and recovers
    for (int n = 0; n < 400; n++) begin
      rv  = ($urandom % 4) != 0;
      sel = $urandom % 16;
      chk = (sel < 2);
      rec = (sel == 2);
      drive_cycle(rv, WAYS'($urandom), arch_vec_t'($urandom), arch_vec_t'($urandom),
                  arch_vec_t'($urandom), chk, rec, CP_W'($urandom), WAYS'($urandom));
    end
    idle_cycles(3);

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: rename.f
+incdir+testbench
hw/rename_pkg.sv
hw/free_list.sv
hw/map_table.sv
hw/rename_group.sv
hw/rename_unit.sv
testbench/tb_rename.sv
